// File: hdl/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// tag 0 means operand already present
`define TAG_W 3
`define DATA_W 32

// byte address, memory wraps at MEM_BYTES
`define ADDR_W 8
`define MEM_BYTES 256

// one slot per tag value
`define SLB_DEPTH 8

`endif

// File: hdl/lsu_pkg.sv
package lsu_pkg;

    // memory ops held in the store/load buffer
    typedef enum logic [3:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } mem_op_e;

    typedef enum logic [1:0] {
        LEN_BYTE,
        LEN_HALF,
        LEN_WORD
    } access_len_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

endpackage

// File: hdl/slb.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module slb (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 disp_en,
    input  lsu_pkg::mem_op_e     disp_op,
    input  logic [`TAG_W-1:0]    disp_tag,
    input  logic [`DATA_W-1:0]   disp_imm,
    input  logic [`TAG_W-1:0]    disp_rs1_tag,
    input  logic [`DATA_W-1:0]   disp_rs1_data,
    input  logic [`TAG_W-1:0]    disp_rs2_tag,
    input  logic [`DATA_W-1:0]   disp_rs2_data,
    input  logic                 store_commit,
    input  logic [`TAG_W-1:0]    store_tag,
    input  logic                 cdb_valid,
    input  logic [`TAG_W-1:0]    cdb_tag,
    input  logic [`DATA_W-1:0]   cdb_data,
    output logic                 mem_req,
    output logic                 mem_we,
    output lsu_pkg::access_len_e mem_len,
    output logic                 mem_unsigned,
    output logic [`TAG_W-1:0]    mem_tag,
    output logic [`ADDR_W-1:0]   mem_addr,
    output logic [`DATA_W-1:0]   mem_wdata,
    input  logic                 mem_rvalid,
    input  logic [`TAG_W-1:0]    mem_rtag,
    input  logic [`DATA_W-1:0]   mem_rdata,
    output logic                 ld_req,
    output logic [`TAG_W-1:0]    ld_tag,
    output logic [`DATA_W-1:0]   ld_data,
    input  logic                 ld_gnt,
    output logic                 slb_full
);
    import lsu_pkg::*;

    logic [`SLB_DEPTH-1:0] occupied, issued, is_store;
    logic [`SLB_DEPTH-1:0] rs1_vld, rs2_vld;
    mem_op_e               op       [`SLB_DEPTH];
    logic [`DATA_W-1:0]    imm      [`SLB_DEPTH];
    logic [`TAG_W-1:0]     rs1_tag  [`SLB_DEPTH];
    logic [`TAG_W-1:0]     rs2_tag  [`SLB_DEPTH];
    logic [`DATA_W-1:0]    rs1_data [`SLB_DEPTH];
    logic [`DATA_W-1:0]    rs2_data [`SLB_DEPTH];

    logic                  ld_found, ld_go, ld_busy, ld_resp, store_go;
    logic [`TAG_W-1:0]     ld_pick;
    logic [`DATA_W-1:0]    st_sum, ld_sum;
    logic                  rs1_byp, rs2_byp;

    function automatic access_len_e op_len(mem_op_e o);
        case (o)
            LB, LBU, SB: op_len = LEN_BYTE;
            LH, LHU, SH: op_len = LEN_HALF;
            default:     op_len = LEN_WORD;
        endcase
    endfunction

    // lowest ready load that has not gone to memory yet
    always_comb begin
        ld_found = 1'b0;
        ld_pick  = '0;
        for (int i = `SLB_DEPTH - 1; i > 0; i--) begin
            if (occupied[i] && !issued[i] && !is_store[i] && rs1_vld[i]) begin
                ld_found = 1'b1;
                ld_pick  = i[`TAG_W-1:0];
            end
        end
    end

    assign store_go = store_commit && occupied[store_tag] && is_store[store_tag]
                      && rs1_vld[store_tag] && rs2_vld[store_tag];
    // one load outstanding at a time, result register must be free
    assign ld_busy  = (ld_req && !ld_gnt) || (mem_req && !mem_we) || mem_rvalid;
    assign ld_go    = ld_found && !store_go && !ld_busy;
    assign ld_resp  = mem_rvalid && occupied[mem_rtag] && issued[mem_rtag]
                      && !is_store[mem_rtag]; // stale responses after flush drop here
    assign st_sum   = rs1_data[store_tag] + imm[store_tag];
    assign ld_sum   = rs1_data[ld_pick] + imm[ld_pick];
    assign rs1_byp  = cdb_valid && disp_rs1_tag != '0 && cdb_tag == disp_rs1_tag;
    assign rs2_byp  = cdb_valid && disp_rs2_tag != '0 && cdb_tag == disp_rs2_tag;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            occupied <= '0;
            issued   <= '0;
            mem_req  <= 1'b0;
            ld_req   <= 1'b0;
            slb_full <= 1'b0;
        end else begin
            slb_full <= &occupied[`SLB_DEPTH-1:1];
            mem_req  <= store_go || ld_go;
            if (ld_req && ld_gnt) begin
                ld_req           <= 1'b0;
                occupied[ld_tag] <= 1'b0;
            end
            if (ld_resp)
                ld_req <= 1'b1;
            if (store_go)
                occupied[store_tag] <= 1'b0;
            if (ld_go)
                issued[ld_pick] <= 1'b1;
            if (disp_en) begin
                occupied[disp_tag] <= 1'b1;
                issued[disp_tag]   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `SLB_DEPTH; i++) begin
            if (cdb_valid && occupied[i]) begin
                if (!rs1_vld[i] && rs1_tag[i] == cdb_tag) begin
                    rs1_vld[i]  <= 1'b1;
                    rs1_data[i] <= cdb_data;
                end
                if (!rs2_vld[i] && rs2_tag[i] == cdb_tag) begin
                    rs2_vld[i]  <= 1'b1;
                    rs2_data[i] <= cdb_data;
                end
            end
        end
        if (disp_en) begin
            op[disp_tag]       <= disp_op;
            imm[disp_tag]      <= disp_imm;
            is_store[disp_tag] <= disp_op inside {SB, SH, SW};
            rs1_tag[disp_tag]  <= disp_rs1_tag;
            rs2_tag[disp_tag]  <= disp_rs2_tag;
            rs1_vld[disp_tag]  <= disp_rs1_tag == '0 || rs1_byp;
            rs2_vld[disp_tag]  <= disp_rs2_tag == '0 || rs2_byp;
            rs1_data[disp_tag] <= rs1_byp ? cdb_data : disp_rs1_data;
            rs2_data[disp_tag] <= rs2_byp ? cdb_data : disp_rs2_data;
        end
        if (ld_resp) begin
            ld_tag  <= mem_rtag;
            ld_data <= mem_rdata;
        end
        if (store_go) begin // commit beats any load
            mem_we       <= 1'b1;
            mem_len      <= op_len(op[store_tag]);
            mem_unsigned <= 1'b0;
            mem_tag      <= store_tag;
            mem_addr     <= st_sum[`ADDR_W-1:0];
            mem_wdata    <= rs2_data[store_tag];
        end else begin
            mem_we       <= 1'b0;
            mem_len      <= op_len(op[ld_pick]);
            mem_unsigned <= op[ld_pick] inside {LBU, LHU};
            mem_tag      <= ld_pick;
            mem_addr     <= ld_sum[`ADDR_W-1:0];
        end
    end

endmodule

// File: hdl/data_mem.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module data_mem (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem_req,
    input  logic                 mem_we,
    input  lsu_pkg::access_len_e mem_len,
    input  logic                 mem_unsigned,
    input  logic [`TAG_W-1:0]    mem_tag,
    input  logic [`ADDR_W-1:0]   mem_addr,
    input  logic [`DATA_W-1:0]   mem_wdata,
    output logic                 mem_rvalid,
    output logic [`TAG_W-1:0]    mem_rtag,
    output logic [`DATA_W-1:0]   mem_rdata
);
    import lsu_pkg::*;

    logic [7:0]         bytes [`MEM_BYTES];
    logic [`ADDR_W-1:0] a1, a2, a3;
    logic [`DATA_W-1:0] rd_ext;

    // little endian, byte lanes wrap with the address
    assign a1 = mem_addr + `ADDR_W'd1;
    assign a2 = mem_addr + `ADDR_W'd2;
    assign a3 = mem_addr + `ADDR_W'd3;

    always_comb begin
        case (mem_len)
            LEN_BYTE: rd_ext = mem_unsigned ? {{(`DATA_W-8){1'b0}}, bytes[mem_addr]}
                                            : {{(`DATA_W-8){bytes[mem_addr][7]}}, bytes[mem_addr]};
            LEN_HALF: rd_ext = mem_unsigned ? {{(`DATA_W-16){1'b0}}, bytes[a1], bytes[mem_addr]}
                                            : {{(`DATA_W-16){bytes[a1][7]}}, bytes[a1],
                                               bytes[mem_addr]};
            default:  rd_ext = {bytes[a3], bytes[a2], bytes[a1], bytes[mem_addr]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MEM_BYTES; i++)
                bytes[i] <= 8'h00;
            mem_rvalid <= 1'b0;
        end else begin
            mem_rvalid <= mem_req && !mem_we;
            if (mem_req && mem_we) begin
                bytes[mem_addr] <= mem_wdata[7:0];
                if (mem_len != LEN_BYTE)
                    bytes[a1] <= mem_wdata[15:8];
                if (mem_len == LEN_WORD) begin
                    bytes[a2] <= mem_wdata[23:16];
                    bytes[a3] <= mem_wdata[31:24];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        mem_rtag  <= mem_tag;
        mem_rdata <= rd_ext;
    end

endmodule

// File: hdl/alu_unit.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module alu_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               alu_en,
    input  lsu_pkg::alu_op_e   alu_op,
    input  logic [`TAG_W-1:0]  alu_tag,
    input  logic [`DATA_W-1:0] alu_a,
    input  logic [`DATA_W-1:0] alu_b,
    output logic               alu_req,
    output logic [`TAG_W-1:0]  alu_rtag,
    output logic [`DATA_W-1:0] alu_rdata,
    output logic               alu_busy,
    input  logic               alu_gnt
);
    import lsu_pkg::*;

    logic [`DATA_W-1:0] result;

    always_comb begin
        case (alu_op)
            ALU_ADD: result = alu_a + alu_b;
            ALU_SUB: result = alu_a - alu_b;
            ALU_AND: result = alu_a & alu_b;
            ALU_OR:  result = alu_a | alu_b;
            ALU_XOR: result = alu_a ^ alu_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            alu_req <= 1'b0;
        else if (alu_en)
            alu_req <= 1'b1;
        else if (alu_gnt)
            alu_req <= 1'b0; // result left on the bus
    end

    always_ff @(posedge clk) begin
        if (alu_en) begin
            alu_rtag  <= alu_tag;
            alu_rdata <= result;
        end
    end

    assign alu_busy = alu_req; // single stage, holding means busy

endmodule

// File: hdl/cdb_arbiter.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module cdb_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic               ld_req,
    input  logic [`TAG_W-1:0]  ld_tag,
    input  logic [`DATA_W-1:0] ld_data,
    input  logic               alu_req,
    input  logic [`TAG_W-1:0]  alu_rtag,
    input  logic [`DATA_W-1:0] alu_rdata,
    output logic               ld_gnt,
    output logic               alu_gnt,
    output logic               cdb_valid,
    output logic [`TAG_W-1:0]  cdb_tag,
    output logic [`DATA_W-1:0] cdb_data
);
    logic last_alu; // alu owned the bus last time

    // on a tie the one that did not win last goes
    assign ld_gnt    = ld_req && (!alu_req || last_alu);
    assign alu_gnt   = alu_req && !ld_gnt;
    assign cdb_valid = ld_req || alu_req;
    assign cdb_tag   = ld_gnt ? ld_tag : alu_rtag;
    assign cdb_data  = ld_gnt ? ld_data : alu_rdata;

    always_ff @(posedge clk) begin
        if (rst)
            last_alu <= 1'b0;
        else if (cdb_valid)
            last_alu <= alu_gnt;
    end

endmodule

// File: hdl/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               disp_en,
    input  lsu_pkg::mem_op_e   disp_op,
    input  logic [`TAG_W-1:0]  disp_tag,
    input  logic [`DATA_W-1:0] disp_imm,
    input  logic [`TAG_W-1:0]  disp_rs1_tag,
    input  logic [`DATA_W-1:0] disp_rs1_data,
    input  logic [`TAG_W-1:0]  disp_rs2_tag,
    input  logic [`DATA_W-1:0] disp_rs2_data,
    input  logic               store_commit,
    input  logic [`TAG_W-1:0]  store_tag,
    input  logic               alu_en,
    input  lsu_pkg::alu_op_e   alu_op,
    input  logic [`TAG_W-1:0]  alu_tag,
    input  logic [`DATA_W-1:0] alu_a,
    input  logic [`DATA_W-1:0] alu_b,
    output logic               alu_busy,
    output logic               slb_full,
    output logic               cdb_valid,
    output logic [`TAG_W-1:0]  cdb_tag,
    output logic [`DATA_W-1:0] cdb_data
);
    import lsu_pkg::*;

    logic               mem_req, mem_we, mem_unsigned, mem_rvalid;
    access_len_e        mem_len;
    logic [`TAG_W-1:0]  mem_tag, mem_rtag, ld_tag, alu_rtag;
    logic [`ADDR_W-1:0] mem_addr;
    logic [`DATA_W-1:0] mem_wdata, mem_rdata, ld_data, alu_rdata;
    logic               ld_req, ld_gnt, alu_req, alu_gnt;

    slb slb_i (.*);

    data_mem data_mem_i (.*);

    alu_unit alu_unit_i (.*);

    cdb_arbiter cdb_arbiter_i (.*);

endmodule

// File: dv/lsu_assert.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_assert (
    input logic               clk,
    input logic               rst,
    input logic               flush,
    input logic               cdb_valid,
    input logic               ld_req,
    input logic               ld_gnt,
    input logic [`TAG_W-1:0]  ld_tag,
    input logic [`DATA_W-1:0] ld_data,
    input logic               alu_req,
    input logic               alu_gnt,
    input logic [`TAG_W-1:0]  alu_rtag,
    input logic [`DATA_W-1:0] alu_rdata,
    input logic               mem_req,
    input logic               mem_we,
    input logic               mem_rvalid
);
    int fail_count = 0;

    one_grant: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> $onehot({ld_gnt, alu_gnt}))
        else begin
            fail_count++;
            $error("CDB valid without exactly one grant");
        end

    // load won last, so a tie goes to the alu
    tie_alt: assert property (@(posedge clk) disable iff (rst)
        (ld_gnt ##1 (ld_req && alu_req)) |-> alu_gnt)
        else begin
            fail_count++;
            $error("tie not granted to the requester that lost last");
        end

    ld_hold: assert property (@(posedge clk) disable iff (rst)
        (ld_req && !ld_gnt && !flush) |=> ld_req && $stable(ld_tag) && $stable(ld_data))
        else begin
            fail_count++;
            $error("load result changed before its grant");
        end

    alu_hold: assert property (@(posedge clk) disable iff (rst)
        (alu_req && !alu_gnt) |=> alu_req && $stable(alu_rtag) && $stable(alu_rdata))
        else begin
            fail_count++;
            $error("ALU result changed before its grant");
        end

    rd_resp: assert property (@(posedge clk) disable iff (rst)
        mem_rvalid == $past(mem_req && !mem_we))
        else begin
            fail_count++;
            $error("memory read response not one cycle after its request");
        end

endmodule

bind lsu_top lsu_assert lsu_assert_i (.*);

// File: dv/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_tb;
    import lsu_pkg::*;

    logic               clk = 1'b0;
    logic               rst, flush, disp_en, store_commit, alu_en;
    mem_op_e            disp_op;
    alu_op_e            alu_op;
    logic [`TAG_W-1:0]  disp_tag, disp_rs1_tag, disp_rs2_tag, store_tag, alu_tag;
    logic [`DATA_W-1:0] disp_imm, disp_rs1_data, disp_rs2_data, alu_a, alu_b;
    logic               alu_busy, slb_full, cdb_valid;
    logic [`TAG_W-1:0]  cdb_tag;
    logic [`DATA_W-1:0] cdb_data;

    logic [7:0]         model_mem [`MEM_BYTES];
    logic [`DATA_W-1:0] exp_data [`SLB_DEPTH];
    string              exp_test [`SLB_DEPTH];
    bit                 pend [`SLB_DEPTH]; // result still owed on the CDB
    mem_op_e            ld_ops [5] = '{LB, LH, LW, LBU, LHU};
    logic [31:0]        rng = 32'hfc39d098;
    logic [31:0]        rng2;
    int                 errors = 0;

    lsu_top dut_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    // little endian load from the model, sign or zero extended
    function automatic logic [31:0] ref_load(mem_op_e op, logic [`ADDR_W-1:0] a);
        logic [7:0] b0, b1, b2, b3;
        b0 = model_mem[a];
        b1 = model_mem[a + 8'd1];
        b2 = model_mem[a + 8'd2];
        b3 = model_mem[a + 8'd3];
        case (op)
            LB:      return {{24{b0[7]}}, b0};
            LBU:     return {24'h0, b0};
            LH:      return {{16{b1[7]}}, b1, b0};
            LHU:     return {16'h0, b1, b0};
            default: return {b3, b2, b1, b0};
        endcase
    endfunction

    function automatic logic [31:0] ref_alu(alu_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            default: return a ^ b;
        endcase
    endfunction

    function automatic void model_store(mem_op_e op, logic [`ADDR_W-1:0] a, logic [31:0] d);
        model_mem[a] = d[7:0];
        if (op != SB)
            model_mem[a + 8'd1] = d[15:8];
        if (op == SW) begin
            model_mem[a + 8'd2] = d[23:16];
            model_mem[a + 8'd3] = d[31:24];
        end
    endfunction

    function automatic bit any_pending();
        bit busy;
        busy = alu_busy;
        for (int t = 0; t < `SLB_DEPTH; t++)
            busy |= pend[t];
        return busy;
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic wait_tag_free(logic [`TAG_W-1:0] tag);
        int n;
        n = 0;
        while (pend[tag]) begin
            @(posedge clk);
            n++;
            if (n > 300) begin
                errors++;
                $display("tag %0d never came back on the CDB", tag);
                pend[tag] = 1'b0;
                break;
            end
        end
    endtask

    task automatic wait_all_done();
        int n;
        n = 0;
        while (any_pending()) begin
            @(posedge clk);
            n++;
            if (n > 500) begin
                errors++;
                $display("results still missing from the CDB after 500 cycles");
                break;
            end
        end
    endtask

    task automatic wait_full(logic level);
        int n;
        n = 0;
        while (slb_full !== level) begin
            @(posedge clk);
            n++;
            if (n > 50) begin
                errors++;
                $display("slb_full did not go to %0d in time", level);
                break;
            end
        end
    endtask

    task automatic expect_result(string name, logic [`TAG_W-1:0] tag, logic [31:0] val);
        wait_tag_free(tag);
        exp_data[tag] = val;
        exp_test[tag] = name;
        pend[tag]     = 1'b1;
    endtask

    task automatic dispatch(mem_op_e op, logic [`TAG_W-1:0] tag, logic [31:0] imm,
                            logic [`TAG_W-1:0] t1, logic [31:0] d1,
                            logic [`TAG_W-1:0] t2, logic [31:0] d2);
        @(posedge clk);
        disp_en       <= 1'b1;
        disp_op       <= op;
        disp_tag      <= tag;
        disp_imm      <= imm;
        disp_rs1_tag  <= t1;
        disp_rs1_data <= d1;
        disp_rs2_tag  <= t2;
        disp_rs2_data <= d2;
        @(posedge clk);
        disp_en       <= 1'b0;
    endtask

    task automatic commit_store(logic [`TAG_W-1:0] tag, mem_op_e op,
                                logic [`ADDR_W-1:0] addr, logic [31:0] d);
        @(posedge clk);
        store_commit <= 1'b1;
        store_tag    <= tag;
        @(posedge clk);
        store_commit <= 1'b0;
        model_store(op, addr, d);
    endtask

    task automatic do_store(mem_op_e op, logic [`TAG_W-1:0] tag,
                            logic [`ADDR_W-1:0] addr, logic [31:0] d);
        dispatch(op, tag, `DATA_W'(addr), '0, 32'h0, '0, d);
        commit_store(tag, op, addr, d);
    endtask

    // random base in rs1, imm makes up the rest of the address
    task automatic do_load(string name, mem_op_e op, logic [`TAG_W-1:0] tag,
                           logic [`ADDR_W-1:0] addr);
        logic [31:0] base;
        rng  = xorshift(rng);
        base = rng;
        expect_result(name, tag, ref_load(op, addr));
        dispatch(op, tag, `DATA_W'(addr) - base, '0, base, '0, 32'h0);
    endtask

    task automatic issue_alu(string name, alu_op_e op, logic [`TAG_W-1:0] tag,
                             logic [31:0] a, logic [31:0] b);
        int n;
        n = 0;
        @(posedge clk);
        while (alu_busy || pend[tag]) begin
            @(posedge clk);
            n++;
            if (n > 300) begin
                errors++;
                $display("ALU stayed busy too long before tag %0d", tag);
                break;
            end
        end
        exp_data[tag] = ref_alu(op, a, b);
        exp_test[tag] = name;
        pend[tag]     = 1'b1;
        alu_en        <= 1'b1;
        alu_op        <= op;
        alu_tag       <= tag;
        alu_a         <= a;
        alu_b         <= b;
        @(posedge clk);
        alu_en        <= 1'b0;
        @(negedge clk);
        check_value({name, "_alu_busy"}, 32'd1, {31'd0, alu_busy}); // held result
    endtask

    // compare process, bus is settled at the falling edge
    always @(negedge clk) begin
        if (!rst && cdb_valid) begin
            if (!pend[cdb_tag]) begin
                errors++;
                $display("tag %0d showed up on the CDB with no result owed", cdb_tag);
            end else begin
                check_value(exp_test[cdb_tag], exp_data[cdb_tag], cdb_data);
                pend[cdb_tag] = 1'b0;
            end
        end
    end

    initial begin
        #1_000_000;
        $display("simulation ran too long and was stopped");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0]        a1, b1, r, a2, b2, d;
        logic [`ADDR_W-1:0] sa;
        logic [`ADDR_W-1:0] addrs [6];
        rst = 1'b1;
        flush = 1'b0;
        disp_en = 1'b0;
        disp_op = LW;
        disp_tag = '0;
        disp_imm = '0;
        disp_rs1_tag = '0;
        disp_rs1_data = '0;
        disp_rs2_tag = '0;
        disp_rs2_data = '0;
        store_commit = 1'b0;
        store_tag = '0;
        alu_en = 1'b0;
        alu_op = ALU_ADD;
        alu_tag = '0;
        alu_a = '0;
        alu_b = '0;
        for (int i = 0; i < `MEM_BYTES; i++)
            model_mem[i] = 8'h00;
        for (int t = 0; t < `SLB_DEPTH; t++)
            pend[t] = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // word round trip
        for (int i = 0; i < 6; i++) begin
            rng = xorshift(rng);
            addrs[i] = rng[7:0] & 8'hfc;
            rng = xorshift(rng);
            do_store(SW, `TAG_W'(i + 1), addrs[i], rng);
        end
        for (int i = 0; i < 6; i++)
            do_load("word_round_trip", LW, `TAG_W'(i + 1), addrs[i]);
        wait_all_done();

        // byte and half stores, then every load size
        rng = xorshift(rng);
        sa = rng[7:0] & 8'hfc;
        do_store(SB, 3'd1, sa, rng);
        do_store(SB, 3'd2, sa + 8'd1, rng | 32'h80); // negative byte
        do_store(SH, 3'd3, sa + 8'd2, rng | 32'h8000);
        do_load("size_ext", LB, 3'd1, sa + 8'd1);
        do_load("size_ext", LBU, 3'd2, sa + 8'd1);
        do_load("size_ext", LH, 3'd3, sa + 8'd2);
        do_load("size_ext", LHU, 3'd4, sa + 8'd2);
        do_load("size_ext", LW, 3'd5, sa);
        do_load("size_ext", LB, 3'd6, sa);
        wait_all_done();

        // store data and load address both come from ALU results
        rng = xorshift(rng);
        sa = rng[7:0] & 8'hfc;
        dispatch(SW, 3'd2, `DATA_W'(sa), 3'd0, 32'h0, 3'd6, 32'h0);
        rng = xorshift(rng);
        a1 = rng;
        rng = xorshift(rng);
        b1 = rng;
        issue_alu("wake_up", ALU_XOR, 3'd6, a1, b1);
        wait_tag_free(3'd6);
        commit_store(3'd2, SW, sa, a1 ^ b1);
        rng = xorshift(rng);
        a1 = rng;
        rng = xorshift(rng);
        b1 = rng;
        r = a1 - b1;
        expect_result("wake_up", 3'd1, ref_load(LW, sa));
        dispatch(LW, 3'd1, `DATA_W'(sa) - r, 3'd5, 32'hdead_beef, 3'd0, 32'h0);
        issue_alu("wake_up", ALU_SUB, 3'd5, a1, b1);
        wait_all_done();

        // loads and ALU ops fight for the bus
        rng2 = ~rng;
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    rng = xorshift(rng);
                    d = rng;
                    do_load("cdb_share", ld_ops[d % 5], `TAG_W'(1 + i % 4), d[15:8] & 8'hfc);
                end
            end
            begin
                for (int j = 0; j < 8; j++) begin
                    rng2 = xorshift(rng2);
                    a2 = rng2;
                    rng2 = xorshift(rng2);
                    b2 = rng2;
                    issue_alu("cdb_share", alu_op_e'(b2 % 5), `TAG_W'(5 + j % 3), a2, b2);
                end
            end
        join
        wait_all_done();

        // fill every slot behind tag 7, which nobody produces
        for (int t = 1; t < `SLB_DEPTH; t++)
            dispatch(LW, `TAG_W'(t), 32'h0, 3'd7, 32'h0, 3'd0, 32'h0);
        wait_full(1'b1);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        wait_full(1'b0);
        repeat (20) @(posedge clk); // flushed tags must stay off the bus
        rng = xorshift(rng);
        do_store(SW, 3'd3, 8'h10, rng);
        do_load("flush", LW, 3'd1, 8'h10);
        issue_alu("flush", ALU_OR, 3'd7, rng, 32'h1);
        wait_all_done();

        $display("errors: %0d check, %0d assertion", errors, dut_i.lsu_assert_i.fail_count);
        if (errors + dut_i.lsu_assert_i.fail_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: src.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/slb.sv
hdl/data_mem.sv
hdl/alu_unit.sv
hdl/cdb_arbiter.sv
hdl/lsu_top.sv
dv/lsu_assert.sv
dv/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsu_pkg.sv
      - hdl/slb.sv
      - hdl/data_mem.sv
      - hdl/alu_unit.sv
      - hdl/cdb_arbiter.sv
      - hdl/lsu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/lsu_assert.sv
      - dv/lsu_tb.sv
